/* include/hist_settings.svh */
`ifndef HIST_SETTINGS_SVH
`define HIST_SETTINGS_SVH

// hit timestamp width from the TDC
`define TIME_W 8

// bin index width, 16 bins per pixel histogram
`define NB 4

// coarse binning, drop the low timestamp bits
`define BIN_SHIFT 3

// pixels served by one histogram memory
`define PIXEL_NUM 8

// hits delivered per pixel in each acquisition
`define DATA_NUM 2

// acquisitions summed into one histogram
`define ACQ_NUM 4

// count width per bin
// counts stop at the all-ones value
`define PEAK_MAX 3

// pixel index width, must cover PIXEL_NUM
`define PIX_W 3

// bank-local address, pixel index on top of the bin index
`define ADDR_W 7

`endif

/* source/hist_pkg.sv */
`include "hist_settings.svh"

package hist_pkg;

    // raw arrival time of one photon hit
    typedef logic [`TIME_W-1:0] time_t;

    // histogram bin after shift and clamp
    typedef logic [`NB-1:0] bin_t;

    // pixel position inside the acquisition order
    typedef logic [`PIX_W-1:0] pixel_t;

    // saturating bin count
    typedef logic [`PEAK_MAX-1:0] count_t;

    // address within one bank
    // upper bits pixel, lower bits bin
    typedef logic [`ADDR_W-1:0] ram_addr_t;

endpackage

/* source/time_binner.sv */
`timescale 1ns/1ps
`include "hist_settings.svh"

module time_binner import hist_pkg::*; (
    input  logic  clk,
    input  logic  res,
    input  logic  hit_valid,
    input  time_t hit_time,
    output logic  bin_valid,
    output bin_t  bin_idx
);

    // width of the shifted timestamp before clamping
    localparam int RAW_W = `TIME_W - `BIN_SHIFT;
    // index of the last bin
    localparam int BIN_MAX = (1 << `NB) - 1;

    logic [RAW_W-1:0] raw_bin;
    bin_t             clamped_bin;

    // coarse bin, low timestamp bits dropped
    assign raw_bin = hit_time[`TIME_W-1:`BIN_SHIFT];

    // late photons pile into the last bin
    // so they are still counted instead of wrapping around
    always_comb begin
        if (raw_bin > RAW_W'(BIN_MAX)) begin
            clamped_bin = bin_t'(BIN_MAX);
        end else begin
            clamped_bin = raw_bin[`NB-1:0];
        end
    end

    // strobe delayed by one cycle
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            bin_valid <= 1'b0;
        end else begin
            bin_valid <= hit_valid;
        end
    end

    // bin index only captured with a hit
    always_ff @(posedge clk) begin
        if (hit_valid) begin
            bin_idx <= clamped_bin;
        end
    end

endmodule

/* source/hist_builder.sv */
`timescale 1ns/1ps
`include "hist_settings.svh"

module hist_builder import hist_pkg::*; (
    input  logic      clk,
    input  logic      res,
    input  logic      bin_valid,
    input  bin_t      bin_idx,
    input  logic      ro_busy,
    output logic      inc_rd_en,
    output ram_addr_t inc_rd_addr,
    input  count_t    inc_rd_data,
    output logic      inc_wr_en,
    output ram_addr_t inc_wr_addr,
    output count_t    inc_wr_data,
    output logic      fill_bank,
    output logic      bank_done,
    output logic      overrun
);

    // counter widths, at least one bit each
    localparam int IN_W  = ($clog2(`DATA_NUM) > 0) ? $clog2(`DATA_NUM) : 1;
    localparam int ACQ_W = ($clog2(`ACQ_NUM) > 0) ? $clog2(`ACQ_NUM) : 1;

    logic [IN_W-1:0]  input_cnt;
    pixel_t           pixel_cnt;
    logic [ACQ_W-1:0] acq_cnt;
    logic             last_input;
    logic             last_pixel;
    logic             last_acq;
    logic             wr_last;
    logic             fwd_q;
    count_t           fwd_data;
    logic             fresh_q;
    logic             fwd_hit;
    logic             swap_now;
    logic             overrun_now;
    count_t           old_cnt;

    // wrap points of the three counters
    assign last_input = input_cnt == IN_W'(`DATA_NUM - 1);
    assign last_pixel = pixel_cnt == pixel_t'(`PIXEL_NUM - 1);
    assign last_acq   = acq_cnt == ACQ_W'(`ACQ_NUM - 1);

    // stage 1, read the current count
    assign inc_rd_en   = bin_valid;
    assign inc_rd_addr = ram_addr_t'({pixel_cnt, bin_idx});

    // hits per pixel, then pixels, then acquisitions
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            input_cnt <= '0;
            pixel_cnt <= '0;
            acq_cnt   <= '0;
        end else if (bin_valid) begin
            if (last_input) begin
                input_cnt <= '0;
                if (last_pixel) begin
                    pixel_cnt <= '0;
                    acq_cnt   <= last_acq ? '0 : acq_cnt + 1'b1;
                end else begin
                    pixel_cnt <= pixel_cnt + 1'b1;
                end
            end else begin
                input_cnt <= input_cnt + 1'b1;
            end
        end
    end

    // completion seen while the last write goes out
    assign swap_now    = wr_last && !ro_busy;
    assign overrun_now = wr_last && ro_busy;

    // RAM returns stale data when the same entry is written this cycle
    assign fwd_hit = inc_rd_en && inc_wr_en && (inc_rd_addr == inc_wr_addr) && !swap_now;

    // stage 2 control
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            inc_wr_en <= 1'b0;
            wr_last   <= 1'b0;
            fwd_q     <= 1'b0;
            fresh_q   <= 1'b0;
        end else begin
            inc_wr_en <= bin_valid;
            wr_last   <= bin_valid && last_input && last_pixel && last_acq;
            fwd_q     <= fwd_hit;
            // read went to the old bank, new bank entry is already cleared
            fresh_q   <= bin_valid && swap_now;
        end
    end

    // stage 2 payload
    always_ff @(posedge clk) begin
        if (bin_valid) begin
            inc_wr_addr <= inc_rd_addr;
        end
        if (fwd_hit) begin
            fwd_data <= inc_wr_data;
        end
    end

    // pick the true previous count
    always_comb begin
        if (fresh_q) begin
            old_cnt = '0;
        end else if (fwd_q) begin
            old_cnt = fwd_data;
        end else begin
            old_cnt = inc_rd_data;
        end
    end

    // increment, holding at full scale
    assign inc_wr_data = (&old_cnt) ? old_cnt : old_cnt + 1'b1;

    // bank swap or sticky overrun
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            bank_done <= 1'b0;
            fill_bank <= 1'b0;
            overrun   <= 1'b0;
        end else begin
            bank_done <= swap_now;
            fill_bank <= fill_bank ^ swap_now;
            overrun   <= overrun | overrun_now;
        end
    end

endmodule

/* source/hist_bank_ram.sv */
`timescale 1ns/1ps
`include "hist_settings.svh"

module hist_bank_ram import hist_pkg::*; (
    input  logic      clk,
    input  logic      res,
    input  logic      fill_bank,
    input  logic      inc_rd_en,
    input  ram_addr_t inc_rd_addr,
    output count_t    inc_rd_data,
    input  logic      inc_wr_en,
    input  ram_addr_t inc_wr_addr,
    input  count_t    inc_wr_data,
    input  logic      clr_en,
    input  ram_addr_t clr_addr,
    output count_t    clr_data
);

    // entries per bank
    localparam int DEPTH = 1 << `ADDR_W;

    count_t bank_mem [2][DEPTH];
    logic   clr_bank;

    // readout always works on the bank not being filled
    assign clr_bank = ~fill_bank;

    // writes from both ports
    // the two ports never share a bank
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            for (int b = 0; b < 2; b++) begin
                for (int a = 0; a < DEPTH; a++) begin
                    bank_mem[b][a] <= '0;
                end
            end
        end else begin
            if (inc_wr_en) begin
                bank_mem[fill_bank][inc_wr_addr] <= inc_wr_data;
            end
            // entry is emptied as it is read out
            if (clr_en) begin
                bank_mem[clr_bank][clr_addr] <= '0;
            end
        end
    end

    // synchronous reads, one cycle latency
    // read returns the value from before a same-cycle write
    always_ff @(posedge clk) begin
        if (inc_rd_en) begin
            inc_rd_data <= bank_mem[fill_bank][inc_rd_addr];
        end
        if (clr_en) begin
            clr_data <= bank_mem[clr_bank][clr_addr];
        end
    end

endmodule

/* source/hist_readout.sv */
`timescale 1ns/1ps
`include "hist_settings.svh"

module hist_readout import hist_pkg::*; (
    input  logic      clk,
    input  logic      res,
    input  logic      bank_done,
    output logic      clr_en,
    output ram_addr_t clr_addr,
    input  count_t    clr_data,
    output logic      ro_busy,
    output logic      rd_valid,
    output pixel_t    rd_pixel,
    output bin_t      rd_bin,
    output count_t    rd_count,
    output logic      rd_last
);

    logic      sweep_on;
    ram_addr_t sweep_addr;
    ram_addr_t lbl_addr;

    // sweep counter
    // pixel in the upper bits so the order is pixel-major
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            sweep_on   <= 1'b0;
            sweep_addr <= '0;
        end else if (bank_done) begin
            sweep_on   <= 1'b1;
            sweep_addr <= '0;
        end else if (sweep_on) begin
            sweep_addr <= sweep_addr + 1'b1;
            // stop after the last entry
            if (&sweep_addr) begin
                sweep_on <= 1'b0;
            end
        end
    end

    // one read-and-clear per cycle
    assign clr_en   = sweep_on;
    assign clr_addr = sweep_addr;

    // output strobes line up with the returned count
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            rd_valid <= 1'b0;
            rd_last  <= 1'b0;
        end else begin
            rd_valid <= clr_en;
            rd_last  <= clr_en && (&clr_addr);
        end
    end

    // address delayed as the label of the count
    always_ff @(posedge clk) begin
        if (clr_en) begin
            lbl_addr <= clr_addr;
        end
    end

    // split the label back into pixel and bin
    assign rd_pixel = lbl_addr[`ADDR_W-1:`NB];
    assign rd_bin   = lbl_addr[`NB-1:0];
    assign rd_count = clr_data;

    // busy from the first address until the last word
    assign ro_busy = sweep_on | rd_valid;

endmodule

/* source/hist_top.sv */
`timescale 1ns/1ps

module hist_top import hist_pkg::*; (
    input  logic   clk,
    input  logic   res,
    input  logic   hit_valid,
    input  time_t  hit_time,
    output logic   rd_valid,
    output pixel_t rd_pixel,
    output bin_t   rd_bin,
    output count_t rd_count,
    output logic   rd_last,
    output logic   fill_bank,
    output logic   overrun
);

    // binner to builder
    logic      bin_valid;
    bin_t      bin_idx;

    // builder to memory
    logic      inc_rd_en;
    ram_addr_t inc_rd_addr;
    count_t    inc_rd_data;
    logic      inc_wr_en;
    ram_addr_t inc_wr_addr;
    count_t    inc_wr_data;

    // builder and readout handshake
    logic      bank_done;
    logic      ro_busy;

    // readout to memory
    logic      clr_en;
    ram_addr_t clr_addr;
    count_t    clr_data;

    time_binner u_binner (
        .clk       (clk),
        .res       (res),
        .hit_valid (hit_valid),
        .hit_time  (hit_time),
        .bin_valid (bin_valid),
        .bin_idx   (bin_idx)
    );

    hist_builder u_builder (
        .clk         (clk),
        .res         (res),
        .bin_valid   (bin_valid),
        .bin_idx     (bin_idx),
        .ro_busy     (ro_busy),
        .inc_rd_en   (inc_rd_en),
        .inc_rd_addr (inc_rd_addr),
        .inc_rd_data (inc_rd_data),
        .inc_wr_en   (inc_wr_en),
        .inc_wr_addr (inc_wr_addr),
        .inc_wr_data (inc_wr_data),
        .fill_bank   (fill_bank),
        .bank_done   (bank_done),
        .overrun     (overrun)
    );

    // two banks, filled and read out in turn
    hist_bank_ram u_ram (
        .clk         (clk),
        .res         (res),
        .fill_bank   (fill_bank),
        .inc_rd_en   (inc_rd_en),
        .inc_rd_addr (inc_rd_addr),
        .inc_rd_data (inc_rd_data),
        .inc_wr_en   (inc_wr_en),
        .inc_wr_addr (inc_wr_addr),
        .inc_wr_data (inc_wr_data),
        .clr_en      (clr_en),
        .clr_addr    (clr_addr),
        .clr_data    (clr_data)
    );

    hist_readout u_readout (
        .clk       (clk),
        .res       (res),
        .bank_done (bank_done),
        .clr_en    (clr_en),
        .clr_addr  (clr_addr),
        .clr_data  (clr_data),
        .ro_busy   (ro_busy),
        .rd_valid  (rd_valid),
        .rd_pixel  (rd_pixel),
        .rd_bin    (rd_bin),
        .rd_count  (rd_count),
        .rd_last   (rd_last)
    );

endmodule

/* test/hist_tb.sv */
`timescale 1ns/1ps
`include "hist_settings.svh"

module hist_tb import hist_pkg::*;;

    // hits in one complete histogram
    localparam int HIST_HITS   = `DATA_NUM * `PIXEL_NUM * `ACQ_NUM;
    localparam int N_BATCHES   = 4;
    localparam int N_HITS      = N_BATCHES * HIST_HITS;
    localparam int NBINS       = 1 << `NB;
    localparam int SWEEP_WORDS = `PIXEL_NUM * NBINS;
    localparam int COUNT_MAX   = (1 << `PEAK_MAX) - 1;
    // three readouts expected, one sweep of 129 cycles each
    localparam int N_SWEEPS    = 3;
    localparam int RES_CYCLES  = 16;
    localparam int LIMIT       = N_HITS + 129 * N_SWEEPS + RES_CYCLES + 200;

    logic   clk;
    logic   res;
    logic   hit_valid;
    time_t  hit_time;
    logic   rd_valid;
    pixel_t rd_pixel;
    bin_t   rd_bin;
    count_t rd_count;
    logic   rd_last;
    logic   fill_bank;
    logic   overrun;

    // stimulus table and expected bin per hit
    time_t  hit_tab [N_HITS];
    bin_t   bin_tab [N_HITS];
    int     model_cnt [SWEEP_WORDS];

    // collected readout words
    pixel_t pix_q [$];
    bin_t   bin_q [$];
    count_t cnt_q [$];
    logic   last_q [$];

    int     value_errors = 0;
    int     other_errors = 0;
    int     cycles = 0;
    int     seed = 32'hb113_805b;

    hist_top dut0 (
        .clk       (clk),
        .res       (res),
        .hit_valid (hit_valid),
        .hit_time  (hit_time),
        .rd_valid  (rd_valid),
        .rd_pixel  (rd_pixel),
        .rd_bin    (rd_bin),
        .rd_count  (rd_count),
        .rd_last   (rd_last),
        .fill_bank (fill_bank),
        .overrun   (overrun)
    );

    always #2 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timed out after %0d cycles waiting for readout words", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    // readout words sampled mid-cycle
    always @(negedge clk) begin
        if (rd_valid) begin
            pix_q.push_back(rd_pixel);
            bin_q.push_back(rd_bin);
            cnt_q.push_back(rd_count);
            last_q.push_back(rd_last);
        end
    end

    // shift, then clamp into the last bin
    function automatic bin_t time_to_bin(input time_t t);
        int raw;
        raw = int'(t) >> `BIN_SHIFT;
        if (raw >= NBINS) begin
            raw = NBINS - 1;
        end
        return bin_t'(raw);
    endfunction

    task automatic check_count(input string name, input count_t exp, input count_t act);
        if (exp !== act) begin
            value_errors++;
            $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_bin(input string name, input bin_t exp, input bin_t act);
        if (exp !== act) begin
            value_errors++;
            $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
        if (exp !== act) begin
            value_errors++;
            $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            value_errors++;
            $display("FAILED %s: expected %0b, actual %0b", name, exp, act);
        end
    endtask

    // batch 0 fixed, the rest random
    task automatic fill_table();
        int k;
        int pix;
        for (k = 0; k < N_HITS; k++) begin
            pix = (k / `DATA_NUM) % `PIXEL_NUM;
            if (k < HIST_HITS) begin
                case (pix)
                    // every hit of pixel 0 in bin 5, saturates
                    0: hit_tab[k] = 8'd40;
                    // out of range, lands in bin 15
                    1: hit_tab[k] = time_t'(128 + k);
                    2: hit_tab[k] = 8'd255;
                    // top of the range without clamping
                    3: hit_tab[k] = 8'd127;
                    default: hit_tab[k] = time_t'(k * 4);
                endcase
            end else if (k < 2 * HIST_HITS) begin
                hit_tab[k] = time_t'($random(seed));
            end else begin
                // few bins only, so the summed batches saturate
                hit_tab[k] = time_t'($random(seed)) & 8'h9f;
            end
            bin_tab[k] = time_to_bin(hit_tab[k]);
        end
    endtask

    // expected histogram over a run of hits
    task automatic build_model(input int first, input int count);
        int k;
        int addr;
        for (k = 0; k < SWEEP_WORDS; k++) begin
            model_cnt[k] = 0;
        end
        for (k = first; k < first + count; k++) begin
            addr = ((k / `DATA_NUM) % `PIXEL_NUM) * NBINS + int'(bin_tab[k]);
            if (model_cnt[addr] < COUNT_MAX) begin
                model_cnt[addr]++;
            end
        end
    endtask

    // back-to-back hits, one per cycle
    task automatic apply_hits(input int first, input int count);
        int k;
        for (k = first; k < first + count; k++) begin
            @(negedge clk);
            hit_valid = 1'b1;
            hit_time  = hit_tab[k];
        end
        @(negedge clk);
        hit_valid = 1'b0;
        hit_time  = '0;
    endtask

    // one full sweep against the model
    task automatic check_sweep(input string tag);
        int i;
        while (cnt_q.size() < SWEEP_WORDS) begin
            @(negedge clk);
        end
        // a few idle cycles to catch extra words
        repeat (4) @(negedge clk);
        if (cnt_q.size() != SWEEP_WORDS) begin
            other_errors++;
            $display("%s readout delivered %0d words instead of %0d",
                     tag, cnt_q.size(), SWEEP_WORDS);
        end
        for (i = 0; i < SWEEP_WORDS; i++) begin
            check_pixel($sformatf("%s word %0d pixel", tag, i), pixel_t'(i / NBINS), pix_q[i]);
            check_bin($sformatf("%s word %0d bin", tag, i), bin_t'(i % NBINS), bin_q[i]);
            check_count($sformatf("%s word %0d count", tag, i), count_t'(model_cnt[i]),
                        cnt_q[i]);
            check_flag($sformatf("%s word %0d last", tag, i), i == SWEEP_WORDS - 1, last_q[i]);
        end
        pix_q.delete();
        bin_q.delete();
        cnt_q.delete();
        last_q.delete();
    endtask

    initial begin
        clk       = 1'b0;
        res       = 1'b0;
        hit_valid = 1'b0;
        hit_time  = '0;
        fill_table();
        repeat (RES_CYCLES) @(negedge clk);
        res = 1'b1;

        // idle after reset
        repeat (20) @(negedge clk);
        if (cnt_q.size() != 0) begin
            other_errors++;
            $display("readout words appeared with no hits applied");
        end
        check_flag("idle fill_bank", 1'b0, fill_bank);
        check_flag("idle overrun", 1'b0, overrun);

        // first histogram, clamping and saturation
        build_model(0, HIST_HITS);
        apply_hits(0, HIST_HITS);
        check_sweep("first");
        check_flag("first fill_bank", 1'b1, fill_bank);
        check_flag("first overrun", 1'b0, overrun);

        // second histogram, third follows while its readout runs
        build_model(HIST_HITS, HIST_HITS);
        apply_hits(HIST_HITS, 2 * HIST_HITS);
        repeat (4) @(negedge clk);
        check_flag("overlap overrun", 1'b1, overrun);
        check_flag("overlap fill_bank", 1'b0, fill_bank);
        check_sweep("second");

        // fourth histogram adds onto the third in the same bank
        build_model(2 * HIST_HITS, 2 * HIST_HITS);
        apply_hits(3 * HIST_HITS, HIST_HITS);
        check_sweep("summed");
        check_flag("summed fill_bank", 1'b1, fill_bank);
        check_flag("summed overrun", 1'b1, overrun);

        $display("errors: %0d wrong values, %0d other", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+include
source/hist_pkg.sv
source/time_binner.sv
source/hist_builder.sv
source/hist_bank_ram.sv
source/hist_readout.sv
source/hist_top.sv
test/hist_tb.sv

/* Bender.yml */
package:
  name: hist

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/hist_pkg.sv
      - source/time_binner.sv
      - source/hist_builder.sv
      - source/hist_bank_ram.sv
      - source/hist_readout.sv
      - source/hist_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - test/hist_tb.sv
